//--- dyuv_decoder.f
source/dyuv_pkg.sv
source/dyuv_delta_stage.sv
source/dyuv_color_stage.sv
source/dyuv_pixel_fifo.sv
source/dyuv_decoder_top.sv
dv/dyuv_decoder_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := dyuv_decoder_tb
FILELIST  := dyuv_decoder.f

BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := sim passed
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/dyuv_decoder_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dyuv_decoder_tb;

    import dyuv_pkg::*;

    localparam int HALF_PERIOD   = 10;
    localparam int NORMAL_BYTES  = 384;
    localparam int ST_BYTES      = 360;
    localparam int SETTLE_CYCLES = 4;

    localparam int PAT_ZERO    = 0;
    localparam int PAT_RAMP    = 1;
    localparam int PAT_EXTREME = 2;
    localparam int PAT_RANDOM  = 3;

    // One row per line
    // A nonzero abort restarts the next line after that many bytes
    localparam int NUM_ROWS = 7;
    localparam int ROW_ST    [NUM_ROWS] = '{0, 1, 0, 0, 0, 1, 0};
    localparam int ROW_Y     [NUM_ROWS] = '{120, 60, 16, 250, 128, 200, 30};
    localparam int ROW_U     [NUM_ROWS] = '{90, 200, 128, 10, 128, 40, 220};
    localparam int ROW_V     [NUM_ROWS] = '{170, 40, 128, 240, 128, 90, 15};
    localparam int ROW_PAT   [NUM_ROWS] = '{PAT_ZERO, PAT_ZERO, PAT_RAMP, PAT_EXTREME,
                                            PAT_RANDOM, PAT_RANDOM, PAT_RANDOM};
    localparam int ROW_IDLE  [NUM_ROWS] = '{0, 0, 0, 0, 30, 20, 10};
    localparam int ROW_STALL [NUM_ROWS] = '{0, 0, 0, 10, 40, 30, 20};
    localparam int ROW_ABORT [NUM_ROWS] = '{0, 0, 0, 0, 0, 101, 0};
    localparam int ROW_DROP  [NUM_ROWS] = '{0, 0, 0, 0, 1, 0, 0};

    logic        clk;
    logic        reset;
    logic        line_start;
    logic        st;
    sample_t     start_y;
    sample_t     start_u;
    sample_t     start_v;
    delta_byte_t in_pixel;
    logic        in_write;
    logic        in_strobe;
    sample_t     out_r;
    sample_t     out_g;
    sample_t     out_b;
    logic        out_write;
    logic        out_strobe;

    // Values applied to the DUT on the next falling edge
    logic        next_line_start;
    logic        next_st;
    sample_t     next_y;
    sample_t     next_u;
    sample_t     next_v;
    logic        next_write;
    delta_byte_t next_pixel;

    delta_byte_t line_mem [NORMAL_BYTES];
    logic [23:0] expected_q [$];
    int          mismatch_count;
    int          other_errors;
    int          pixels_checked;
    int          stall_pct;
    int          stall_run;
    int          low_hits [3];
    int          high_hits [3];

    dyuv_decoder_top uut (
        .clk        (clk),
        .reset      (reset),
        .line_start (line_start),
        .st         (st),
        .start_y    (start_y),
        .start_u    (start_u),
        .start_v    (start_v),
        .in_pixel   (in_pixel),
        .in_write   (in_write),
        .in_strobe  (in_strobe),
        .out_r      (out_r),
        .out_g      (out_g),
        .out_b      (out_b),
        .out_write  (out_write),
        .out_strobe (out_strobe)
    );

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    function automatic int line_length(input int row);
        int result;
        if (ROW_ABORT[row] != 0) begin
            result = ROW_ABORT[row];
        end else begin
            result = (ROW_ST[row] != 0) ? ST_BYTES : NORMAL_BYTES;
        end
        return result;
    endfunction

    task automatic compare(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("[FAIL] %0t %s: actual %0d, expected %0d", $time, name, actual, expected);
            mismatch_count++;
        end
    endtask

    // Integer YUV to RGB matrix, truncating divide, then clamp
    task automatic push_rgb(input int y, input int u, input int v);
        int raw [3];
        int val [3];
        raw[0] = (256 * y + 351 * (v - 128)) / 256;
        raw[1] = (256 * y - 86 * (u - 128) - 179 * (v - 128)) / 256;
        raw[2] = (256 * y + 444 * (u - 128)) / 256;
        for (int c = 0; c < 3; c++) begin
            val[c] = raw[c];
            if (raw[c] < 0) begin
                val[c] = 0;
                low_hits[c]++;
            end else if (raw[c] > 255) begin
                val[c] = 255;
                high_hits[c]++;
            end
        end
        expected_q.push_back({val[0][7:0], val[1][7:0], val[2][7:0]});
    endtask

    task automatic build_expected(input int row, input int nbytes);
        int ys [NORMAL_BYTES];
        int us [NORMAL_BYTES/2];
        int vs [NORMAL_BYTES/2];
        int y;
        int u;
        int v;
        int m;
        int m1;
        int npix;
        y = ROW_Y[row];
        u = ROW_U[row];
        v = ROW_V[row];
        for (int k = 0; k < nbytes; k++) begin
            y = (y + int'(DELTA_TABLE[line_mem[k][3:0]])) % 256;
            ys[k] = y;
            if (k % 2 == 0) begin
                u = (u + int'(DELTA_TABLE[line_mem[k][7:4]])) % 256;
                us[k/2] = u;
            end else begin
                v = (v + int'(DELTA_TABLE[line_mem[k][7:4]])) % 256;
                vs[k/2] = v;
            end
        end
        // A restarted line loses the two pixels still waiting for later bytes
        npix = nbytes;
        if (ROW_ABORT[row] != 0) begin
            npix = (nbytes > 2) ? nbytes - 2 : 0;
        end
        for (int k = 0; k < npix; k++) begin
            m = k / 2;
            if (k % 2 == 0) begin
                push_rgb(ys[k], us[m], vs[m]);
            end else begin
                m1 = (m + 1 < nbytes / 2) ? m + 1 : m;
                push_rgb(ys[k], (us[m] + us[m1]) / 2, (vs[m] + vs[m1]) / 2);
            end
        end
    endtask

    task automatic check_pixel();
        logic [23:0] exp_rgb;
        if (expected_q.size() == 0) begin
            $display("Error at %0t: the DUT delivered a pixel that was not expected", $time);
            other_errors++;
        end else begin
            exp_rgb = expected_q.pop_front();
            compare("out_r", out_r, exp_rgb[23:16]);
            compare("out_g", out_g, exp_rgb[15:8]);
            compare("out_b", out_b, exp_rgb[7:0]);
            pixels_checked++;
        end
    endtask

    // Drive on the falling edge, sample just before the rising edge
    task automatic step_cycle(output logic accepted);
        @(negedge clk);
        line_start = next_line_start;
        st         = next_st;
        start_y    = next_y;
        start_u    = next_u;
        start_v    = next_v;
        in_write   = next_write;
        in_pixel   = next_pixel;
        if (stall_run > 0) begin
            out_strobe = 1'b0;
            stall_run--;
        end else if (int'($urandom % 100) < stall_pct) begin
            out_strobe = 1'b0;
            stall_run  = int'($urandom % 8);
        end else begin
            out_strobe = 1'b1;
        end
        #(HALF_PERIOD - 1);
        accepted = in_write && in_strobe;
        if (out_write && out_strobe) begin
            check_pixel();
        end
    endtask

    task automatic run_line(input int row);
        int   nbytes;
        int   sent;
        int   drops;
        int   settle;
        logic accepted;
        nbytes = line_length(row);
        for (int k = 0; k < nbytes; k++) begin
            case (ROW_PAT[row])
                PAT_ZERO: line_mem[k] = 8'h00;
                PAT_RAMP: line_mem[k] = delta_byte_t'(k);
                PAT_EXTREME: begin
                    line_mem[k] = {((k >> 3) % 3 == 0) ? 4'd7 : 4'd8,
                                   ((k >> 2) % 2 == 1) ? 4'd7 : 4'd8};
                end
                default: line_mem[k] = delta_byte_t'($urandom);
            endcase
        end
        build_expected(row, nbytes);
        stall_pct       = ROW_STALL[row];
        next_line_start = 1'b1;
        next_st         = (ROW_ST[row] != 0);
        next_y          = sample_t'(ROW_Y[row]);
        next_u          = sample_t'(ROW_U[row]);
        next_v          = sample_t'(ROW_V[row]);
        next_write      = 1'b0;
        step_cycle(accepted);
        next_line_start = 1'b0;
        sent  = 0;
        drops = 0;
        while (sent < nbytes) begin
            next_write = (int'($urandom % 100) >= ROW_IDLE[row]);
            next_pixel = line_mem[sent];
            step_cycle(accepted);
            if (accepted) begin
                sent++;
            end else if (next_write) begin
                drops++;
            end
        end
        if (ROW_DROP[row] != 0 && drops == 0) begin
            $display("Error: in_strobe never dropped while the pipeline was full (line %0d)", row);
            other_errors++;
        end
        if (ROW_ABORT[row] == 0) begin
            // Source keeps offering bytes while the line drains and the pipeline settles
            next_write = 1'b1;
            next_pixel = 8'hff;
            settle     = 0;
            while (expected_q.size() != 0 || settle < SETTLE_CYCLES) begin
                if (expected_q.size() == 0) begin
                    settle++;
                end
                step_cycle(accepted);
                if (accepted) begin
                    $display("Error at %0t: a byte was accepted past the end of line %0d",
                             $time, row);
                    other_errors++;
                end
            end
            // Nothing may be left in the output queue once the line is complete
            compare("out_write", out_write, 0);
        end
        next_write = 1'b0;
    endtask

    initial begin : watchdog
        int limit;
        int cycles;
        limit = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit += line_length(r);
        end
        limit  = 4 * limit + 200;
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Error: timeout after %0d cycles with %0d expected pixels not delivered",
                 cycles, expected_q.size());
        $display("Summary: %0d pixels checked, %0d value mismatches, %0d other errors",
                 pixels_checked, mismatch_count, other_errors + 1);
        $display("sim failed");
        $finish;
    end

    initial begin : main
        void'($urandom(67));
        reset           = 1'b1;
        line_start      = 1'b0;
        st              = 1'b0;
        start_y         = '0;
        start_u         = '0;
        start_v         = '0;
        in_pixel        = '0;
        in_write        = 1'b0;
        out_strobe      = 1'b0;
        next_line_start = 1'b0;
        next_st         = 1'b0;
        next_y          = '0;
        next_u          = '0;
        next_v          = '0;
        next_write      = 1'b0;
        next_pixel      = '0;
        mismatch_count  = 0;
        other_errors    = 0;
        pixels_checked  = 0;
        stall_pct       = 0;
        stall_run       = 0;
        for (int c = 0; c < 3; c++) begin
            low_hits[c]  = 0;
            high_hits[c] = 0;
        end
        repeat (5) @(negedge clk);
        reset = 1'b0;
        #(HALF_PERIOD - 1);
        compare("in_strobe", in_strobe, 0);
        compare("out_write", out_write, 0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_line(r);
        end

        for (int c = 0; c < 3; c++) begin
            if (low_hits[c] == 0 || high_hits[c] == 0) begin
                $display("Error: color component %0d never reached both clamp limits", c);
                other_errors++;
            end
        end
        $display("Summary: %0d pixels checked, %0d value mismatches, %0d other errors",
                 pixels_checked, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/dyuv_decoder_top.sv
`timescale 1ns/1ps
`default_nettype none

module dyuv_decoder_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  line_start,
    input  logic                  st,
    input  dyuv_pkg::sample_t     start_y,
    input  dyuv_pkg::sample_t     start_u,
    input  dyuv_pkg::sample_t     start_v,
    input  dyuv_pkg::delta_byte_t in_pixel,
    input  logic                  in_write,
    output logic                  in_strobe,
    output dyuv_pkg::sample_t     out_r,
    output dyuv_pkg::sample_t     out_g,
    output dyuv_pkg::sample_t     out_b,
    output logic                  out_write,
    input  logic                  out_strobe
);

    import dyuv_pkg::*;

    // Delta stage to color stage
    sample_t yuv_y;
    sample_t yuv_u;
    sample_t yuv_v;
    logic    yuv_valid;
    logic    yuv_ready;

    // Color stage to output queue
    sample_t rgb_r;
    sample_t rgb_g;
    sample_t rgb_b;
    logic    rgb_valid;
    logic    rgb_ready;

    dyuv_delta_stage u_delta (
        .clk        (clk),
        .reset      (reset),
        .line_start (line_start),
        .st         (st),
        .start_y    (start_y),
        .start_u    (start_u),
        .start_v    (start_v),
        .in_pixel   (in_pixel),
        .in_write   (in_write),
        .in_strobe  (in_strobe),
        .yuv_y      (yuv_y),
        .yuv_u      (yuv_u),
        .yuv_v      (yuv_v),
        .yuv_valid  (yuv_valid),
        .yuv_ready  (yuv_ready)
    );

    dyuv_color_stage u_color (
        .clk       (clk),
        .reset     (reset),
        .yuv_y     (yuv_y),
        .yuv_u     (yuv_u),
        .yuv_v     (yuv_v),
        .yuv_valid (yuv_valid),
        .yuv_ready (yuv_ready),
        .rgb_r     (rgb_r),
        .rgb_g     (rgb_g),
        .rgb_b     (rgb_b),
        .rgb_valid (rgb_valid),
        .rgb_ready (rgb_ready)
    );

    dyuv_pixel_fifo u_fifo (
        .clk        (clk),
        .reset      (reset),
        .rgb_r      (rgb_r),
        .rgb_g      (rgb_g),
        .rgb_b      (rgb_b),
        .rgb_valid  (rgb_valid),
        .rgb_ready  (rgb_ready),
        .out_r      (out_r),
        .out_g      (out_g),
        .out_b      (out_b),
        .out_write  (out_write),
        .out_strobe (out_strobe)
    );

endmodule

`default_nettype wire

//--- source/dyuv_pixel_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module dyuv_pixel_fifo (
    input  logic              clk,
    input  logic              reset,
    input  dyuv_pkg::sample_t rgb_r,
    input  dyuv_pkg::sample_t rgb_g,
    input  dyuv_pkg::sample_t rgb_b,
    input  logic              rgb_valid,
    output logic              rgb_ready,
    output dyuv_pkg::sample_t out_r,
    output dyuv_pkg::sample_t out_g,
    output dyuv_pkg::sample_t out_b,
    output logic              out_write,
    input  logic              out_strobe
);

    import dyuv_pkg::*;

    sample_t     mem_r [FIFO_DEPTH];
    sample_t     mem_g [FIFO_DEPTH];
    sample_t     mem_b [FIFO_DEPTH];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;
    logic        push;
    logic        pop;

    // Ready depends on occupancy only
    assign rgb_ready = (count != fifo_count_t'(FIFO_DEPTH));
    assign out_write = (count != '0);

    assign push = rgb_valid && rgb_ready;
    assign pop  = out_write && out_strobe;

    // Head entry stays on the port until the consumer takes it
    assign out_r = mem_r[rd_ptr];
    assign out_g = mem_g[rd_ptr];
    assign out_b = mem_b[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_r[wr_ptr] <= rgb_r;
            mem_g[wr_ptr] <= rgb_g;
            mem_b[wr_ptr] <= rgb_b;
        end
    end

endmodule

`default_nettype wire

//--- source/dyuv_color_stage.sv
`timescale 1ns/1ps
`default_nettype none

module dyuv_color_stage (
    input  logic              clk,
    input  logic              reset,
    input  dyuv_pkg::sample_t yuv_y,
    input  dyuv_pkg::sample_t yuv_u,
    input  dyuv_pkg::sample_t yuv_v,
    input  logic              yuv_valid,
    output logic              yuv_ready,
    output dyuv_pkg::sample_t rgb_r,
    output dyuv_pkg::sample_t rgb_g,
    output dyuv_pkg::sample_t rgb_b,
    output logic              rgb_valid,
    input  logic              rgb_ready
);

    import dyuv_pkg::*;

    rgb_sum_t y_term;
    rgb_sum_t u_off;
    rgb_sum_t v_off;
    rgb_sum_t r_sum;
    rgb_sum_t g_sum;
    rgb_sum_t b_sum;
    rgb_int_t r_int;
    rgb_int_t g_int;
    rgb_int_t b_int;
    logic     take;

    assign yuv_ready = !rgb_valid || rgb_ready;
    assign take      = yuv_valid && yuv_ready;

    // Chroma is centered on 128
    assign y_term = rgb_sum_t'({2'b00, yuv_y, 8'h00});
    assign u_off  = rgb_sum_t'({10'd0, yuv_u}) - 18'sd128;
    assign v_off  = rgb_sum_t'({10'd0, yuv_v}) - 18'sd128;

    assign r_sum = y_term + 18'sd351 * v_off;
    assign g_sum = y_term - 18'sd86 * u_off - 18'sd179 * v_off;
    assign b_sum = y_term + 18'sd444 * u_off;

    // Signed divide truncates toward zero
    assign r_int = rgb_int_t'(r_sum / 18'sd256);
    assign g_int = rgb_int_t'(g_sum / 18'sd256);
    assign b_int = rgb_int_t'(b_sum / 18'sd256);

    always_ff @(posedge clk) begin
        if (reset) begin
            rgb_valid <= 1'b0;
        end else if (yuv_ready) begin
            rgb_valid <= yuv_valid;
        end
    end

    // Result register doubles as the back-pressure hold
    always_ff @(posedge clk) begin
        if (take) begin
            rgb_r <= clamp8(r_int);
            rgb_g <= clamp8(g_int);
            rgb_b <= clamp8(b_int);
        end
    end

endmodule

`default_nettype wire

//--- source/dyuv_delta_stage.sv
`timescale 1ns/1ps
`default_nettype none

module dyuv_delta_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  line_start,
    input  logic                  st,
    input  dyuv_pkg::sample_t     start_y,
    input  dyuv_pkg::sample_t     start_u,
    input  dyuv_pkg::sample_t     start_v,
    input  dyuv_pkg::delta_byte_t in_pixel,
    input  logic                  in_write,
    output logic                  in_strobe,
    output dyuv_pkg::sample_t     yuv_y,
    output dyuv_pkg::sample_t     yuv_u,
    output dyuv_pkg::sample_t     yuv_v,
    output logic                  yuv_valid,
    input  logic                  yuv_ready
);

    import dyuv_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        STATE_UY,
        STATE_VY,
        FLUSH
    } state_t;

    state_t      state;
    word_count_t word_count;
    logic [1:0]  fill;
    logic        flush_last;

    // Running values, newest and the one before it
    sample_t y_new;
    sample_t y_prev;
    sample_t u_new;
    sample_t u_prev;
    sample_t v_new;

    logic        slot_free;
    logic        line_active;
    logic        accept;
    logic        flush_step;
    logic        step;
    logic        odd_step;
    logic        emit;
    delta_code_t luma_code;
    delta_code_t chroma_code;
    sample_t     y_delta;
    sample_t     c_delta;
    sample_t     y_next;
    sample_t     c_next;
    logic [8:0]  u_sum;
    logic [8:0]  v_sum;
    sample_t     pix_u;
    sample_t     pix_v;

    assign slot_free   = !yuv_valid || yuv_ready;
    assign line_active = (state == STATE_UY) || (state == STATE_VY);

    assign in_strobe  = line_active && (word_count != '0) && slot_free && !line_start;
    assign accept     = in_write && in_strobe;
    assign flush_step = (state == FLUSH) && slot_free && !line_start;

    // A flush step acts as a byte of zero deltas
    assign step     = accept || flush_step;
    assign odd_step = (state == STATE_VY) || ((state == FLUSH) && flush_last);

    // First pixel leaves with the third byte
    assign emit = step && fill[1];

    assign luma_code   = in_pixel[CODE_W-1:0];
    assign chroma_code = in_pixel[2*CODE_W-1:CODE_W];

    assign y_delta = (state == FLUSH) ? '0 : DELTA_TABLE[luma_code];
    assign c_delta = (state == FLUSH) ? '0 : DELTA_TABLE[chroma_code];
    assign y_next  = y_new + y_delta;
    assign c_next  = (odd_step ? v_new : u_new) + c_delta;

    // Odd pixels average the chroma pairs on either side
    assign u_sum = {1'b0, u_prev} + {1'b0, u_new};
    assign v_sum = {1'b0, v_new} + {1'b0, c_next};
    assign pix_u = odd_step ? u_sum[8:1] : u_new;
    assign pix_v = odd_step ? v_sum[8:1] : v_new;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            word_count <= '0;
            fill       <= '0;
            flush_last <= 1'b0;
        end else if (line_start) begin
            state      <= STATE_UY;
            word_count <= st ? LINE_WORDS_ST : LINE_WORDS_NORMAL;
            fill       <= '0;
            flush_last <= 1'b0;
        end else if (step) begin
            fill <= {fill[0], 1'b1};
            case (state)
                STATE_UY: begin
                    state <= STATE_VY;
                end
                STATE_VY: begin
                    // Last byte of the line is always a V/Y byte
                    if (word_count == word_count_t'(1)) begin
                        state <= FLUSH;
                    end else begin
                        state <= STATE_UY;
                    end
                end
                FLUSH: begin
                    flush_last <= 1'b1;
                    if (flush_last) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
            if (accept) begin
                word_count <= word_count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_start) begin
            y_new  <= start_y;
            y_prev <= start_y;
            u_new  <= start_u;
            u_prev <= start_u;
            v_new  <= start_v;
        end else if (step) begin
            y_prev <= y_new;
            y_new  <= y_next;
            if (odd_step) begin
                v_new <= c_next;
            end else begin
                u_prev <= u_new;
                u_new  <= c_next;
            end
        end
    end

    // Output slot keeps a pending pixel across a line restart
    always_ff @(posedge clk) begin
        if (reset) begin
            yuv_valid <= 1'b0;
        end else if (slot_free) begin
            yuv_valid <= emit;
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            yuv_y <= y_prev;
            yuv_u <= pix_u;
            yuv_v <= pix_v;
        end
    end

endmodule

`default_nettype wire

//--- source/dyuv_pkg.sv
`default_nettype none

package dyuv_pkg;

    localparam int SAMPLE_W = 8;
    localparam int CODE_W   = 4;
    localparam int COUNT_W  = 9;

    // Color matrix precision, quotient and full product sum
    localparam int RGB_INT_W = 10;
    localparam int RGB_SUM_W = 18;

    localparam int FIFO_DEPTH = 2;

    typedef logic [SAMPLE_W-1:0]        sample_t;
    typedef logic [2*CODE_W-1:0]        delta_byte_t;
    typedef logic [CODE_W-1:0]          delta_code_t;
    typedef logic [COUNT_W-1:0]         word_count_t;
    typedef logic signed [RGB_INT_W-1:0] rgb_int_t;
    typedef logic signed [RGB_SUM_W-1:0] rgb_sum_t;

    typedef logic [$clog2(FIFO_DEPTH)-1:0]   fifo_ptr_t;
    typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count_t;

    // Bytes per line, normal and st mode
    localparam word_count_t LINE_WORDS_NORMAL = 9'd384;
    localparam word_count_t LINE_WORDS_ST     = 9'd360;

    // Dequantized deltas, added modulo 256
    localparam sample_t DELTA_TABLE [16] = '{
        8'd0,
        8'd1,
        8'd4,
        8'd9,
        8'd16,
        8'd27,
        8'd44,
        8'd79,
        8'd128,
        8'd177,
        8'd212,
        8'd229,
        8'd240,
        8'd247,
        8'd252,
        8'd255
    };

    function automatic sample_t clamp8(input rgb_int_t val);
        sample_t result;
        if (val > 10'sd255) begin
            result = 8'd255;
        end else if (val < 10'sd0) begin
            result = 8'd0;
        end else begin
            result = val[SAMPLE_W-1:0];
        end
        return result;
    endfunction

endpackage

`default_nettype wire
